// File: hw/csrPkg.sv
package csrPkg;

    localparam int TIMER_N = 20;

    // DA set, PLV 0, IE 0
    localparam logic [8:0] CRMD_RESET = 9'h8;

    // ecode sits in arg[5:0], subcode in arg[14:6]
    localparam logic [5:0] ECODE_INT = 6'h0;
    localparam logic [5:0] ECODE_ADE = 6'h8;
    localparam logic [8:0] ESUB_ADEF = 9'h0;

    // instruction class and privileged subtypes from the pipeline
    localparam logic [3:0] TYPE_PRIV   = 4'd3;
    localparam logic [4:0] SUB_ERTN    = 5'd6;
    localparam logic [4:0] SUB_IDLE    = 5'd7;
    localparam logic [4:0] SUB_CSRRD   = 5'd8;
    localparam logic [4:0] SUB_CSRWR   = 5'd9;
    localparam logic [4:0] SUB_CSRXCHG = 5'd10;
    localparam logic [4:0] SUB_EXCP    = 5'd13;

    typedef enum logic [2:0] {NOP, RD, WR, XCHG, ERTN, EXCP, IDLE} csrOpE;

    typedef enum logic [13:0] {
        CSR_CRMD   = 14'h0,
        CSR_PRMD   = 14'h1,
        CSR_ECFG   = 14'h4,
        CSR_ESTAT  = 14'h5,
        CSR_ERA    = 14'h6,
        CSR_BADV   = 14'h7,
        CSR_EENTRY = 14'hc,
        CSR_SAVE0  = 14'h30,
        CSR_SAVE1  = 14'h31,
        CSR_SAVE2  = 14'h32,
        CSR_SAVE3  = 14'h33,
        CSR_TID    = 14'h40,
        CSR_TCFG   = 14'h41,
        CSR_TVAL   = 14'h42,
        CSR_TICLR  = 14'h44
    } csrNumE;

    typedef enum logic [1:0] {KIND_NONE, KIND_ENTER, KIND_RETURN} trapKindE;

    typedef struct packed {
        csrOpE       op;
        csrNumE      num;
        logic [31:0] wdata;
        logic [31:0] wmask;
        logic [31:0] pc;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] badv;
    } csrReqT;

    typedef struct packed {
        logic [8:0]  crmd;
        logic [2:0]  prmd;
        logic [12:0] ecfgLie;
        logic [12:0] estatIs;
        logic [31:0] era;
        logic [25:0] eentry;
    } csrStateT;

    typedef struct packed {
        trapKindE    kind;
        logic [31:0] era;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] badv;
        logic        badvValid;
    } trapUpdT;

    typedef struct packed {
        logic               en;
        logic               periodic;
        logic [TIMER_N-1:0] initVal;
    } timerCfgT;

endpackage

// File: hw/csrRequestDecode.sv
`timescale 1ns/1ns

module csrRequestDecode (
    input  logic           reqValid,
    input  logic           pipeStall,
    input  logic           pipeFlush,
    input  logic [3:0]     reqType,
    input  logic [4:0]     reqSubtype,
    input  logic [15:0]    reqArg,
    input  logic [31:0]    reqDin,
    input  logic [31:0]    reqMask,
    input  logic [31:0]    reqPc,
    input  logic [31:0]    reqBadv,
    output csrPkg::csrReqT req
);
    logic          accept;
    logic          knownNum;
    csrPkg::csrOpE op;

    assign accept = reqValid && !pipeStall && !pipeFlush;

    always_comb
    begin
        op = csrPkg::NOP;
        if (accept && reqType == csrPkg::TYPE_PRIV)
        begin
            case (reqSubtype)
                csrPkg::SUB_CSRRD:
                    op = csrPkg::RD;
                csrPkg::SUB_CSRWR:
                    op = csrPkg::WR;
                csrPkg::SUB_CSRXCHG:
                    op = csrPkg::XCHG;
                csrPkg::SUB_ERTN:
                    op = csrPkg::ERTN;
                csrPkg::SUB_EXCP:
                    op = csrPkg::EXCP;
                csrPkg::SUB_IDLE:
                    op = csrPkg::IDLE;
                default:
                    op = csrPkg::NOP;
            endcase
        end
    end

    always_comb
    begin
        req          = '0;
        req.op       = op;
        req.num      = csrPkg::csrNumE'(reqArg[13:0]);
        req.wdata    = reqDin;
        // plain write replaces the whole register
        req.wmask    = (op == csrPkg::WR) ? '1 : ((op == csrPkg::XCHG) ? reqMask : '0);
        req.pc       = reqPc;
        req.ecode    = reqArg[5:0];
        req.esubcode = reqArg[14:6];
        req.badv     = reqBadv;
        // fetch address error faults on the pc itself
        if (reqArg[5:0] == csrPkg::ECODE_ADE && reqArg[14:6] == csrPkg::ESUB_ADEF)
            req.badv = reqPc;
    end

    always_comb
    begin
        case (req.num)
            csrPkg::CSR_CRMD, csrPkg::CSR_PRMD, csrPkg::CSR_ECFG, csrPkg::CSR_ESTAT,
            csrPkg::CSR_ERA, csrPkg::CSR_BADV, csrPkg::CSR_EENTRY,
            csrPkg::CSR_SAVE0, csrPkg::CSR_SAVE1, csrPkg::CSR_SAVE2, csrPkg::CSR_SAVE3,
            csrPkg::CSR_TID, csrPkg::CSR_TCFG, csrPkg::CSR_TVAL, csrPkg::CSR_TICLR:
                knownNum = 1'b1;
            default:
                knownNum = 1'b0;
        endcase
        if (req.op == csrPkg::XCHG)
        begin
            assert (knownNum)
            else $error("xchg to unsupported csr %h", req.num);
        end
    end

endmodule

// File: hw/csrFile.sv
`timescale 1ns/1ns

module csrFile (
    input  logic                       clk,
    input  logic                       rstn,
    input  csrPkg::csrReqT             req,
    input  csrPkg::trapUpdT            upd,
    input  logic                       tiFlag,
    input  logic [csrPkg::TIMER_N-1:0] tval,
    output csrPkg::csrStateT           state,
    output csrPkg::timerCfgT           tcfg,
    output logic                       tcfgWrite,
    output logic                       tiClear,
    output logic [31:0]                dout
);
    logic [8:0]                 crmd;
    logic [2:0]                 prmd;
    logic [12:0]                ecfgLie;
    logic [1:0]                 swIs;
    logic [5:0]                 ecode;
    logic [8:0]                 esubcode;
    logic [31:0]                era;
    logic [31:0]                badv;
    logic [25:0]                eentry;
    logic [31:0]                save [0:3];
    logic [31:0]                tid;
    logic [csrPkg::TIMER_N-1:0] tcfgReg;
    logic [csrPkg::TIMER_N-1:0] tcfgCur;
    logic [12:0]                isVec;
    logic [31:0]                newVal;
    logic                       wrEn;

    assign wrEn   = (req.op == csrPkg::WR || req.op == csrPkg::XCHG)
                    && upd.kind == csrPkg::KIND_NONE;
    // dout already holds the old value of the addressed register
    assign newVal = (dout & ~req.wmask) | (req.wdata & req.wmask);
    assign isVec  = {1'b0, tiFlag, 1'b0, 8'b0, swIs};

    assign tcfgWrite = wrEn && req.num == csrPkg::CSR_TCFG;
    assign tiClear   = wrEn && req.num == csrPkg::CSR_TICLR && newVal[0];

    // timer sees the new config on the write edge
    assign tcfgCur       = tcfgWrite ? newVal[csrPkg::TIMER_N-1:0] : tcfgReg;
    assign tcfg.en       = tcfgCur[0];
    assign tcfg.periodic = tcfgCur[1];
    assign tcfg.initVal  = {tcfgCur[csrPkg::TIMER_N-1:2], 2'b00};

    assign state.crmd    = crmd;
    assign state.prmd    = prmd;
    assign state.ecfgLie = ecfgLie;
    assign state.estatIs = isVec;
    assign state.era     = era;
    assign state.eentry  = eentry;

    always_comb
    begin
        case (req.num)
            csrPkg::CSR_CRMD:
                dout = {23'b0, crmd};
            csrPkg::CSR_PRMD:
                dout = {29'b0, prmd};
            csrPkg::CSR_ECFG:
                dout = {19'b0, ecfgLie};
            csrPkg::CSR_ESTAT:
                dout = {1'b0, esubcode, ecode, 3'b0, isVec};
            csrPkg::CSR_ERA:
                dout = era;
            csrPkg::CSR_BADV:
                dout = badv;
            csrPkg::CSR_EENTRY:
                dout = {eentry, 6'b0};
            csrPkg::CSR_SAVE0, csrPkg::CSR_SAVE1, csrPkg::CSR_SAVE2, csrPkg::CSR_SAVE3:
                dout = save[req.num[1:0]];
            csrPkg::CSR_TID:
                dout = tid;
            csrPkg::CSR_TCFG:
                dout = 32'(tcfgReg);
            csrPkg::CSR_TVAL:
                dout = 32'(tval);
            default:
                dout = 32'h0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd     <= csrPkg::CRMD_RESET;
            prmd     <= '0;
            ecfgLie  <= '0;
            swIs     <= '0;
            ecode    <= '0;
            esubcode <= '0;
            eentry   <= '0;
            save     <= '{default: 32'h0};
            tid      <= '0;
            tcfgReg  <= '0;
        end
        else if (upd.kind == csrPkg::KIND_ENTER)
        begin
            prmd      <= crmd[2:0];
            crmd[2:0] <= 3'b0;
            ecode     <= upd.ecode;
            esubcode  <= upd.esubcode;
        end
        else if (upd.kind == csrPkg::KIND_RETURN)
            crmd[2:0] <= prmd;
        else if (wrEn)
        begin
            case (req.num)
                csrPkg::CSR_CRMD:
                    crmd <= newVal[8:0];
                csrPkg::CSR_PRMD:
                    prmd <= newVal[2:0];
                // lie bit 10 is reserved
                csrPkg::CSR_ECFG:
                    ecfgLie <= newVal[12:0] & 13'h1bff;
                csrPkg::CSR_ESTAT:
                    swIs <= newVal[1:0];
                csrPkg::CSR_EENTRY:
                    eentry <= newVal[31:6];
                csrPkg::CSR_SAVE0, csrPkg::CSR_SAVE1, csrPkg::CSR_SAVE2, csrPkg::CSR_SAVE3:
                    save[req.num[1:0]] <= newVal;
                csrPkg::CSR_TID:
                    tid <= newVal;
                csrPkg::CSR_TCFG:
                    tcfgReg <= newVal[csrPkg::TIMER_N-1:0];
                default:
                begin
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (upd.kind == csrPkg::KIND_ENTER)
        begin
            era <= upd.era;
            if (upd.badvValid)
                badv <= upd.badv;
        end
        else if (wrEn && req.num == csrPkg::CSR_ERA)
            era <= newVal;
        else if (wrEn && req.num == csrPkg::CSR_BADV)
            badv <= newVal;
    end

    // only an interrupt may land on top of a csr write
    assert property (@(posedge clk) disable iff (!rstn)
        (upd.kind != csrPkg::KIND_NONE && (req.op == csrPkg::WR || req.op == csrPkg::XCHG))
        |-> (upd.kind == csrPkg::KIND_ENTER && upd.ecode == csrPkg::ECODE_INT))
    else $error("csr write collides with a non-interrupt trap");

endmodule

// File: hw/trapControl.sv
`timescale 1ns/1ns

module trapControl (
    input  logic             clk,
    input  logic             rstn,
    input  csrPkg::csrReqT   req,
    input  csrPkg::csrStateT state,
    input  logic [7:0]       hwInt,
    input  logic             tiFlag,
    output csrPkg::trapUpdT  upd,
    output logic             flush,
    output logic             stall,
    output logic [31:0]      outPc,
    output logic             clkStall
);
    logic [12:0] intVec;
    logic        intPending;

    // is bits from the top are ipi, ti, reserved, hw[7:0] and sw[1:0]
    assign intVec = {state.estatIs[12], tiFlag, state.estatIs[10], hwInt, state.estatIs[1:0]};
    assign intPending = (|(intVec & state.ecfgLie)) && state.crmd[2];

    assign flush = intPending || req.op == csrPkg::EXCP || req.op == csrPkg::ERTN;
    assign stall = flush;

    always_comb
    begin
        upd      = '0;
        upd.era  = req.pc;
        upd.badv = req.badv;
        outPc    = {state.eentry, 6'b0};
        if (intPending)
        begin
            upd.kind     = csrPkg::KIND_ENTER;
            upd.ecode    = csrPkg::ECODE_INT;
            upd.esubcode = '0;
        end
        else if (req.op == csrPkg::EXCP)
        begin
            upd.kind      = csrPkg::KIND_ENTER;
            upd.ecode     = req.ecode;
            upd.esubcode  = req.esubcode;
            upd.badvValid = req.ecode == csrPkg::ECODE_ADE
                            && req.esubcode == csrPkg::ESUB_ADEF;
        end
        else if (req.op == csrPkg::ERTN)
        begin
            upd.kind = csrPkg::KIND_RETURN;
            outPc    = state.era;
        end
    end

    // idle gates the core clock until an interrupt is taken
    always_ff @(posedge clk)
    begin
        if (!rstn)
            clkStall <= 1'b0;
        else if (intPending)
            clkStall <= 1'b0;
        else if (req.op == csrPkg::IDLE)
            clkStall <= 1'b1;
    end

    // a taken trap must reach the csr file
    assert property (@(posedge clk) disable iff (!rstn)
        upd.kind == csrPkg::KIND_ENTER |=> state.crmd[2:0] == 3'b0)
    else $error("trap entry left plv or ie set");

endmodule

// File: hw/stableTimer.sv
`timescale 1ns/1ns

module stableTimer (
    input  logic                       clk,
    input  logic                       rstn,
    input  csrPkg::timerCfgT           tcfg,
    input  logic                       tcfgWrite,
    input  logic                       tiClear,
    output logic [csrPkg::TIMER_N-1:0] tval,
    output logic                       tiFlag
);
    logic armed;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tval   <= '0;
            armed  <= 1'b0;
            tiFlag <= 1'b0;
        end
        else
        begin
            if (tiClear)
                tiFlag <= 1'b0;
            if (tcfgWrite)
            begin
                tval  <= tcfg.initVal;
                armed <= tcfg.en;
            end
            else if (armed)
            begin
                if (tval == '0)
                begin
                    // set wins over a clear on the same edge
                    tiFlag <= 1'b1;
                    if (tcfg.periodic)
                        tval <= tcfg.initVal;
                    else
                    begin
                        tval  <= '1;
                        armed <= 1'b0;
                    end
                end
                else
                    tval <= tval - 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
        (!armed && !tcfgWrite) |=> (!armed && $stable(tval)))
    else $error("stopped timer restarted without a tcfg write");

endmodule

// File: hw/csrUnit.sv
`timescale 1ns/1ns

module csrUnit (
    input  logic        clk,
    input  logic        rstn,
    input  logic        reqValid,
    input  logic        pipeStall,
    input  logic        pipeFlush,
    input  logic [3:0]  reqType,
    input  logic [4:0]  reqSubtype,
    input  logic [15:0] reqArg,
    input  logic [31:0] reqDin,
    input  logic [31:0] reqMask,
    input  logic [31:0] reqPc,
    input  logic [31:0] reqBadv,
    input  logic [7:0]  hwInt,
    output logic [31:0] csrDout,
    output logic        csrFlush,
    output logic [31:0] csrOutPc,
    output logic        csrStall,
    output logic        clkStall
);
    csrPkg::csrReqT             req;
    csrPkg::csrStateT           state;
    csrPkg::trapUpdT            upd;
    csrPkg::timerCfgT           tcfg;
    logic                       tcfgWrite;
    logic                       tiClear;
    logic                       tiFlag;
    logic [csrPkg::TIMER_N-1:0] tval;

    csrRequestDecode decode_i (
        .reqValid  (reqValid),
        .pipeStall (pipeStall),
        .pipeFlush (pipeFlush),
        .reqType   (reqType),
        .reqSubtype(reqSubtype),
        .reqArg    (reqArg),
        .reqDin    (reqDin),
        .reqMask   (reqMask),
        .reqPc     (reqPc),
        .reqBadv   (reqBadv),
        .req       (req)
    );

    csrFile file_i (
        .clk      (clk),
        .rstn     (rstn),
        .req      (req),
        .upd      (upd),
        .tiFlag   (tiFlag),
        .tval     (tval),
        .state    (state),
        .tcfg     (tcfg),
        .tcfgWrite(tcfgWrite),
        .tiClear  (tiClear),
        .dout     (csrDout)
    );

    trapControl trap_i (
        .clk     (clk),
        .rstn    (rstn),
        .req     (req),
        .state   (state),
        .hwInt   (hwInt),
        .tiFlag  (tiFlag),
        .upd     (upd),
        .flush   (csrFlush),
        .stall   (csrStall),
        .outPc   (csrOutPc),
        .clkStall(clkStall)
    );

    stableTimer timer_i (
        .clk      (clk),
        .rstn     (rstn),
        .tcfg     (tcfg),
        .tcfgWrite(tcfgWrite),
        .tiClear  (tiClear),
        .tval     (tval),
        .tiFlag   (tiFlag)
    );

endmodule

// File: tests/csrUnitTb.sv
`timescale 1ns/1ns

module csrUnitTb;
    localparam int MAX_CYCLES = 4000;

    logic        clk;
    logic        rstn;
    logic        reqValid;
    logic        pipeStall;
    logic        pipeFlush;
    logic [3:0]  reqType;
    logic [4:0]  reqSubtype;
    logic [15:0] reqArg;
    logic [31:0] reqDin;
    logic [31:0] reqMask;
    logic [31:0] reqPc;
    logic [31:0] reqBadv;
    logic [7:0]  hwInt;
    logic [31:0] csrDout;
    logic        csrFlush;
    logic [31:0] csrOutPc;
    logic        csrStall;
    logic        clkStall;
    int          errors;
    int          cycles;

    // shadow copy of the architectural state
    logic [8:0]  mCrmd;
    logic [2:0]  mPrmd;
    logic [12:0] mLie;
    logic [5:0]  mEcode;
    logic [8:0]  mEsub;
    logic [31:0] mEra;
    logic [31:0] mBadv;
    logic [25:0] mEentry;
    logic [31:0] mSave [0:3];
    logic [31:0] mTid;
    logic [19:0] mTcfg;
    logic [19:0] mTval;
    logic        mArmed;
    logic        mTi;
    logic        mIdle;

    logic        isAcc, isRd, isWr, isXchg, isExcp, isErtn, isIdle;
    logic        pend, expFlush, doWrite;
    logic [13:0] num;
    logic [31:0] oldVal, newVal, wmask, expPc;

    csrUnit dut_i (.*);

    function automatic logic [31:0] modelRead(input logic [13:0] n);
        case (n)
            14'h0: return {23'b0, mCrmd};
            14'h1: return {29'b0, mPrmd};
            14'h4: return {19'b0, mLie};
            14'h5: return {1'b0, mEsub, mEcode, 3'b0, 1'b0, mTi, 11'b0};
            14'h6: return mEra;
            14'h7: return mBadv;
            14'hc: return {mEentry, 6'b0};
            14'h30, 14'h31, 14'h32, 14'h33: return mSave[n[1:0]];
            14'h40: return mTid;
            14'h41: return {12'b0, mTcfg};
            14'h42: return {12'b0, mTval};
            default: return 32'h0;
        endcase
    endfunction

    always_comb
    begin
        isAcc    = reqValid && !pipeStall && !pipeFlush && reqType == csrPkg::TYPE_PRIV;
        isRd     = isAcc && reqSubtype == csrPkg::SUB_CSRRD;
        isWr     = isAcc && reqSubtype == csrPkg::SUB_CSRWR;
        isXchg   = isAcc && reqSubtype == csrPkg::SUB_CSRXCHG;
        isExcp   = isAcc && reqSubtype == csrPkg::SUB_EXCP;
        isErtn   = isAcc && reqSubtype == csrPkg::SUB_ERTN;
        isIdle   = isAcc && reqSubtype == csrPkg::SUB_IDLE;
        num      = reqArg[13:0];
        oldVal   = modelRead(num);
        wmask    = isWr ? 32'hffffffff : reqMask;
        newVal   = (oldVal & ~wmask) | (reqDin & wmask);
        pend     = (|({1'b0, mTi, 1'b0, hwInt, 2'b0} & mLie)) && mCrmd[2];
        expFlush = pend || isExcp || isErtn;
        expPc    = (!pend && isErtn) ? mEra : {mEentry, 6'b0};
        doWrite  = (isWr || isXchg) && !pend;
    end

    always @(posedge clk)
    begin
        if (!rstn)
        begin
            mCrmd  <= csrPkg::CRMD_RESET;
            mPrmd  <= '0;
            mLie   <= '0;
            mEcode <= '0;
            mEsub  <= '0;
            mEra   <= '0;
            mBadv  <= '0;
            mEentry <= '0;
            mSave  <= '{default: 32'h0};
            mTid   <= '0;
            mTcfg  <= '0;
            mTval  <= '0;
            mArmed <= 1'b0;
            mTi    <= 1'b0;
            mIdle  <= 1'b0;
        end
        else
        begin
            if (doWrite && num == 14'h44 && newVal[0])
                mTi <= 1'b0;
            if (doWrite && num == 14'h41)
            begin
                mTval  <= {newVal[19:2], 2'b00};
                mArmed <= newVal[0];
            end
            else if (mArmed)
            begin
                if (mTval == '0)
                begin
                    mTi <= 1'b1;
                    if (mTcfg[1])
                        mTval <= {mTcfg[19:2], 2'b00};
                    else
                    begin
                        mTval  <= '1;
                        mArmed <= 1'b0;
                    end
                end
                else
                    mTval <= mTval - 1'b1;
            end
            if (pend)
                mIdle <= 1'b0;
            else if (isIdle)
                mIdle <= 1'b1;
            if (pend || isExcp)
            begin
                mPrmd      <= mCrmd[2:0];
                mCrmd[2:0] <= 3'b0;
                mEra       <= reqPc;
                mEcode     <= pend ? 6'h0 : reqArg[5:0];
                mEsub      <= pend ? 9'h0 : reqArg[14:6];
                // fetch address error records the faulting pc
                if (!pend && reqArg[5:0] == csrPkg::ECODE_ADE && reqArg[14:6] == csrPkg::ESUB_ADEF)
                    mBadv <= reqPc;
            end
            else if (isErtn)
                mCrmd[2:0] <= mPrmd;
            else if (doWrite)
            begin
                case (num)
                    14'h0: mCrmd <= newVal[8:0];
                    14'h1: mPrmd <= newVal[2:0];
                    14'h4: mLie <= newVal[12:0] & 13'h1bff;
                    14'h6: mEra <= newVal;
                    14'h7: mBadv <= newVal;
                    14'hc: mEentry <= newVal[31:6];
                    14'h30, 14'h31, 14'h32, 14'h33: mSave[num[1:0]] <= newVal;
                    14'h40: mTid <= newVal;
                    14'h41: mTcfg <= newVal[19:0];
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) csrFlush == expFlush)
    else
    begin
        errors++;
        $display("Error at %0t: csrFlush expected %0b got %0b", $time,
                 $sampled(expFlush), $sampled(csrFlush));
    end

    assert property (@(posedge clk) disable iff (!rstn) csrStall == expFlush)
    else
    begin
        errors++;
        $display("Error at %0t: csrStall expected %0b got %0b", $time,
                 $sampled(expFlush), $sampled(csrStall));
    end

    assert property (@(posedge clk) disable iff (!rstn) expFlush |-> csrOutPc == expPc)
    else
    begin
        errors++;
        $display("Error at %0t: csrOutPc expected %h got %h", $time,
                 $sampled(expPc), $sampled(csrOutPc));
    end

    assert property (@(posedge clk) disable iff (!rstn) clkStall == mIdle)
    else
    begin
        errors++;
        $display("Error at %0t: clkStall expected %0b got %0b", $time,
                 $sampled(mIdle), $sampled(clkStall));
    end

    assert property (@(posedge clk) disable iff (!rstn)
        (isRd || isWr || isXchg) |-> csrDout == oldVal)
    else
    begin
        errors++;
        $display("Error at %0t: csrDout expected %h got %h", $time,
                 $sampled(oldVal), $sampled(csrDout));
    end

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("run stopped after %0d cycles without finishing, %0d errors", cycles, errors);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic issue(input logic [4:0] sub, input logic [15:0] arg, input logic [31:0] din,
                         input logic [31:0] mask, input logic [31:0] pc, input logic stl,
                         input logic fls);
        @(posedge clk);
        reqValid   <= 1'b1;
        reqType    <= csrPkg::TYPE_PRIV;
        reqSubtype <= sub;
        reqArg     <= arg;
        reqDin     <= din;
        reqMask    <= mask;
        reqPc      <= pc;
        pipeStall  <= stl;
        pipeFlush  <= fls;
        @(posedge clk);
        reqValid  <= 1'b0;
        pipeStall <= 1'b0;
        pipeFlush <= 1'b0;
    endtask

    task automatic csrRead(input csrPkg::csrNumE n);
        issue(csrPkg::SUB_CSRRD, 16'(n), 32'h0, 32'h0, 32'h0, 1'b0, 1'b0);
    endtask

    task automatic csrWrite(input csrPkg::csrNumE n, input logic [31:0] d);
        issue(csrPkg::SUB_CSRWR, 16'(n), d, 32'h0, 32'h0, 1'b0, 1'b0);
    endtask

    task automatic csrXchg(input csrPkg::csrNumE n, input logic [31:0] d, input logic [31:0] m);
        issue(csrPkg::SUB_CSRXCHG, 16'(n), d, m, 32'h0, 1'b0, 1'b0);
    endtask

    // hold an ESTAT read until TI shows up
    task automatic waitTimerFlag(input int bound);
        int n;
        n = 0;
        @(posedge clk);
        reqValid   <= 1'b1;
        reqType    <= csrPkg::TYPE_PRIV;
        reqSubtype <= csrPkg::SUB_CSRRD;
        reqArg     <= 16'(csrPkg::CSR_ESTAT);
        @(negedge clk);
        while (!csrDout[11] && n <= bound)
        begin
            n++;
            @(negedge clk);
        end
        if (!csrDout[11])
        begin
            errors++;
            $display("timer interrupt bit not set in ESTAT within %0d cycles", bound);
        end
        @(posedge clk);
        reqValid <= 1'b0;
    endtask

    task automatic idleUntilWake(input int bound);
        int n;
        n = 0;
        issue(csrPkg::SUB_IDLE, 16'h0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0);
        @(negedge clk);
        while (clkStall && n < bound)
        begin
            n++;
            @(negedge clk);
        end
        if (clkStall)
        begin
            errors++;
            $display("clock stall did not release after IDLE within %0d cycles", bound);
        end
    endtask

    initial
    begin
        csrPkg::csrNumE targets [0:5];
        int k;
        void'($urandom(32'hb8d4));
        targets = '{csrPkg::CSR_SAVE0, csrPkg::CSR_SAVE1, csrPkg::CSR_SAVE2,
                    csrPkg::CSR_SAVE3, csrPkg::CSR_TID, csrPkg::CSR_ECFG};
        errors = 0;
        cycles = 0;
        rstn = 1'b0;
        reqValid = 1'b0;
        pipeStall = 1'b0;
        pipeFlush = 1'b0;
        reqType = '0;
        reqSubtype = '0;
        reqArg = '0;
        reqDin = '0;
        reqMask = '0;
        reqPc = '0;
        reqBadv = '0;
        hwInt = '0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;

        // reset values
        csrRead(csrPkg::CSR_CRMD);
        csrRead(csrPkg::CSR_PRMD);
        csrRead(csrPkg::CSR_ECFG);
        csrRead(csrPkg::CSR_TCFG);
        for (k = 0; k < 4; k++)
            csrRead(targets[k]);

        // random writes and exchanges with some blocked by the pipeline
        for (k = 0; k < 80; k++)
        begin
            issue(($urandom % 2) ? csrPkg::SUB_CSRWR : csrPkg::SUB_CSRXCHG,
                  16'(targets[$urandom % 6]), $urandom, $urandom, 32'h0,
                  ($urandom % 5) == 0, ($urandom % 7) == 0);
            csrRead(targets[$urandom % 6]);
        end

        // exceptions and return
        csrWrite(csrPkg::CSR_ECFG, 32'h0);
        csrWrite(csrPkg::CSR_EENTRY, $urandom);
        csrWrite(csrPkg::CSR_CRMD, 32'h7);
        for (k = 0; k < 6; k++)
        begin
            issue(csrPkg::SUB_EXCP, {1'b0, 9'($urandom), 6'($urandom)}, 32'h0, 32'h0,
                  $urandom, 1'b0, 1'b0);
            csrRead(csrPkg::CSR_ERA);
            csrRead(csrPkg::CSR_PRMD);
            csrRead(csrPkg::CSR_CRMD);
            csrRead(csrPkg::CSR_ESTAT);
            issue(csrPkg::SUB_ERTN, 16'h0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0);
            csrRead(csrPkg::CSR_CRMD);
        end
        issue(csrPkg::SUB_EXCP, 16'h0008, 32'h0, 32'h0, $urandom, 1'b0, 1'b0);
        csrRead(csrPkg::CSR_BADV);
        issue(csrPkg::SUB_ERTN, 16'h0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0);

        // hardware interrupt beats a concurrent write
        csrWrite(csrPkg::CSR_ECFG, 32'h4);
        csrXchg(csrPkg::CSR_CRMD, 32'h4, 32'h4);
        @(posedge clk);
        hwInt      <= 8'h01;
        reqValid   <= 1'b1;
        reqSubtype <= csrPkg::SUB_CSRWR;
        reqArg     <= 16'(csrPkg::CSR_SAVE0);
        reqDin     <= $urandom;
        reqPc      <= $urandom;
        @(posedge clk);
        reqValid <= 1'b0;
        hwInt    <= 8'h00;
        csrRead(csrPkg::CSR_SAVE0);
        csrRead(csrPkg::CSR_ESTAT);
        issue(csrPkg::SUB_ERTN, 16'h0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0);
        csrXchg(csrPkg::CSR_CRMD, 32'h0, 32'h4);
        @(posedge clk);
        hwInt <= 8'h01;
        repeat (4) @(posedge clk);
        hwInt <= 8'h00;

        // one-shot timer, clear, then IDLE woken by the timer
        csrWrite(csrPkg::CSR_ECFG, 32'h0);
        csrWrite(csrPkg::CSR_TCFG, 32'h21);
        waitTimerFlag(32 + 2);
        csrWrite(csrPkg::CSR_TICLR, 32'h1);
        csrRead(csrPkg::CSR_ESTAT);
        csrWrite(csrPkg::CSR_ECFG, 32'h800);
        csrXchg(csrPkg::CSR_CRMD, 32'h4, 32'h4);
        csrWrite(csrPkg::CSR_TCFG, 32'h41);
        idleUntilWake(200);
        csrWrite(csrPkg::CSR_TICLR, 32'h1);
        csrRead(csrPkg::CSR_ESTAT);
        repeat (4) @(posedge clk);

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: list.f
hw/csrPkg.sv
hw/csrRequestDecode.sv
hw/csrFile.sv
hw/trapControl.sv
hw/stableTimer.sv
hw/csrUnit.sv
tests/csrUnitTb.sv

// File: run.sh
#!/bin/sh
# build and run the csr unit testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module csrUnitTb \
    -o simv --Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi
cat sim.log

if grep -q "Simulation passed" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
